// ==== common/ex_pkg.sv ====
package ex_pkg;

    // index of each operation in the one-hot alu_op field
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // decoded instruction from the decode stage
    typedef struct packed {
        logic [11:0] alu_op;
        logic [31:0] src1;
        logic [31:0] src2;
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] pc;
        logic        st_b;
        logic        st_h;
        logic        st_w;
        logic [31:0] rkd_value;
        logic        ld_b;
        logic        ld_bu;
        logic        ld_h;
        logic        ld_hu;
        logic        ld_w;
        logic        rdcntvl;
        logic        rdcntvh;
        logic        res_from_mul;
        logic        mul_signed;
        logic        mul_h;
        logic        res_from_div;
        logic        div_signed;
        logic        div_r;
    } id_to_ex_t;

    // csr access and exception flags carried down the pipe
    typedef struct packed {
        logic        res_from_csr;
        logic [13:0] csr_num;
        logic        csr_we;
        logic [31:0] csr_wmask;
        logic [31:0] csr_wvalue;
        logic        ertn_flush;
        logic        has_int;
        logic        adef;
        logic        syscall;
        logic        brk;
        logic        ale;
        logic        ine;
    } excep_t;

    typedef struct packed {
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] pc;
        logic [31:0] result;
        logic        ld_b;
        logic        ld_bu;
        logic        ld_h;
        logic        ld_hu;
        logic        ld_w;
        logic        res_from_mul;
        logic        mul_h;
        logic        res_from_div;
    } ex_to_mem_t;

    // forwarding bundle to decode
    // blocking marks a result that is not ready yet
    typedef struct packed {
        logic        res_from_csr;
        logic        blocking;
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] result;
    } ex_fwd_t;

endpackage

// ==== verilog/alu.sv ====
module alu (
    input  logic [11:0] alu_op,
    input  logic [31:0] alu_src1,
    input  logic [31:0] alu_src2,
    output logic [31:0] alu_result
);
    import ex_pkg::*;

    logic        use_sub;
    logic [31:0] adder_b;
    logic [32:0] adder_sum;
    logic        slt_res;
    logic        sltu_res;
    logic [4:0]  shamt;
    logic [31:0] sll_res;
    logic [31:0] srl_res;
    logic [31:0] sra_res;

    // one adder serves add, sub and both compares
    assign use_sub   = alu_op[alu_sub] | alu_op[alu_slt] | alu_op[alu_sltu];
    assign adder_b   = use_sub ? ~alu_src2 : alu_src2;
    assign adder_sum = {1'b0, alu_src1} + {1'b0, adder_b} + {32'd0, use_sub};

    // differing signs decide directly and otherwise the sign of the difference does
    assign slt_res  = (alu_src1[31] & ~alu_src2[31])
                    | (~(alu_src1[31] ^ alu_src2[31]) & adder_sum[31]);
    // no carry out of a - b is a borrow
    assign sltu_res = ~adder_sum[32];

    assign shamt   = alu_src2[4:0];
    assign sll_res = alu_src1 << shamt;
    assign srl_res = alu_src1 >> shamt;
    assign sra_res = $signed(alu_src1) >>> shamt;

    always_comb begin
        alu_result = ({32{alu_op[alu_add] | alu_op[alu_sub]}} & adder_sum[31:0])
                   | {31'd0, alu_op[alu_slt] & slt_res}
                   | {31'd0, alu_op[alu_sltu] & sltu_res}
                   | ({32{alu_op[alu_and]}} & (alu_src1 & alu_src2))
                   | ({32{alu_op[alu_nor]}} & ~(alu_src1 | alu_src2))
                   | ({32{alu_op[alu_or]}}  & (alu_src1 | alu_src2))
                   | ({32{alu_op[alu_xor]}} & (alu_src1 ^ alu_src2))
                   | ({32{alu_op[alu_sll]}} & sll_res)
                   | ({32{alu_op[alu_srl]}} & srl_res)
                   | ({32{alu_op[alu_sra]}} & sra_res)
                   | ({32{alu_op[alu_lui]}} & alu_src2);
    end

    // decode never selects two operations at once
    always_comb begin
        assert ($onehot0(alu_op))
            else $error("alu_op has more than one bit set: %b", alu_op);
    end

endmodule

// ==== verilog/mul.sv ====
module mul (
    input  logic        clk,
    input  logic        resetn,
    input  logic        mul_signed,
    input  logic [31:0] x,
    input  logic [31:0] y,
    output logic [63:0] result
);
    logic signed [32:0] x_ext;
    logic signed [32:0] y_ext;
    logic signed [16:0] x_lo;
    logic signed [16:0] x_hi;
    logic signed [16:0] y_lo;
    logic signed [16:0] y_hi;
    logic signed [33:0] pp_ll;
    logic signed [33:0] pp_lh;
    logic signed [33:0] pp_hl;
    logic signed [33:0] pp_hh;

    assign x_ext = {mul_signed & x[31], x};
    assign y_ext = {mul_signed & y[31], y};

    // low halves are positive and high halves carry the sign
    assign x_lo = {1'b0, x_ext[15:0]};
    assign x_hi = x_ext[32:16];
    assign y_lo = {1'b0, y_ext[15:0]};
    assign y_hi = y_ext[32:16];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pp_ll <= '0;
            pp_lh <= '0;
            pp_hl <= '0;
            pp_hh <= '0;
        end else begin
            pp_ll <= x_lo * y_lo;
            pp_lh <= x_lo * y_hi;
            pp_hl <= x_hi * y_lo;
            pp_hh <= x_hi * y_hi;
        end
    end

    // second stage sums modulo 2^64
    assign result = {pp_hh[31:0], 32'd0}
                  + ({{30{pp_lh[33]}}, pp_lh} << 16)
                  + ({{30{pp_hl[33]}}, pp_hl} << 16)
                  + {{30{pp_ll[33]}}, pp_ll};

endmodule

// ==== verilog/div.sv ====
module div (
    input  logic        clk,
    input  logic        resetn,
    input  logic        start,
    input  logic        div_signed,
    input  logic [31:0] x,
    input  logic [31:0] y,
    output logic [31:0] s,
    output logic [31:0] r,
    output logic        complete
);
    logic        busy;
    logic [5:0]  step_cnt;
    logic        neg_q;
    logic        neg_r;
    logic [31:0] divisor;
    logic [31:0] x_abs;
    logic [31:0] y_abs;
    logic [31:0] rem_in;
    logic [31:0] quo_in;
    logic [31:0] dvs_in;
    logic [32:0] shifted;
    logic [33:0] diff;
    logic [31:0] rem_next;
    logic [31:0] quo_next;
    logic        step_en;

    assign x_abs = (div_signed & x[31]) ? -x : x;
    assign y_abs = (div_signed & y[31]) ? -y : y;

    // the start edge already does the first step
    assign rem_in = start ? 32'd0 : r;
    assign quo_in = start ? x_abs : s;
    assign dvs_in = start ? y_abs : divisor;

    // restoring step with quotient bits shifting in from the right
    assign shifted  = {rem_in, quo_in[31]};
    assign diff     = {1'b0, shifted} - {2'b00, dvs_in};
    assign rem_next = diff[33] ? shifted[31:0] : diff[31:0];
    assign quo_next = {quo_in[30:0], ~diff[33]};

    assign step_en = start | (busy & (step_cnt != 6'd32));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy     <= 1'b0;
            complete <= 1'b0;
            step_cnt <= 6'd0;
        end else if (start) begin
            busy     <= 1'b1;
            complete <= 1'b0;
            step_cnt <= 6'd1;
        end else if (busy) begin
            if (step_cnt == 6'd32) begin
                busy     <= 1'b0;
                complete <= 1'b1;
            end else begin
                step_cnt <= step_cnt + 6'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            divisor <= y_abs;
            // zero divisor keeps the all-ones quotient
            neg_q   <= div_signed & (x[31] ^ y[31]) & (|y);
            neg_r   <= div_signed & x[31];
        end
        if (step_en) begin
            r <= rem_next;
            s <= quo_next;
        end else if (busy) begin
            // sign fix
            s <= neg_q ? -s : s;
            r <= neg_r ? -r : r;
        end
    end

    no_start_while_busy: assert property (
        @(posedge clk) disable iff (!resetn) start |-> !busy);

endmodule

// ==== ex_stage/ex_stage.sv ====
module ex_stage (
    input  logic               clk,
    input  logic               resetn,
    input  logic               id_to_ex_valid,
    input  ex_pkg::id_to_ex_t  id_to_ex_data,
    input  ex_pkg::excep_t     id_to_ex_excep,
    output logic               ex_allowin,
    input  logic               mem_allowin,
    output logic               ex_to_mem_valid,
    output ex_pkg::ex_to_mem_t ex_to_mem_data,
    output ex_pkg::excep_t     ex_to_mem_excep,
    output ex_pkg::ex_fwd_t    ex_fwd,
    output logic               data_sram_en,
    output logic [3:0]         data_sram_we,
    output logic [31:0]        data_sram_addr,
    output logic [31:0]        data_sram_wdata,
    input  logic               ex_flush,
    input  logic               mem_to_ex_excep,
    output logic [11:0]        alu_op,
    output logic [31:0]        alu_src1,
    output logic [31:0]        alu_src2,
    input  logic [31:0]        alu_result,
    output logic               mul_signed,
    output logic               div_start,
    output logic               div_signed,
    input  logic [31:0]        div_s,
    input  logic [31:0]        div_r,
    input  logic               div_complete
);
    import ex_pkg::*;

    logic        ex_valid;
    id_to_ex_t   inst;
    excep_t      excep;
    logic        accept;
    logic        div_issued;
    logic        ready_go;
    logic [63:0] timer;
    logic [31:0] result;
    logic        is_load;
    logic [1:0]  addr_lo;
    logic [3:0]  st_lanes;
    logic        misalign;
    logic        ale;

    assign accept = id_to_ex_valid & ex_allowin;

    // a divide waits for the divider it started itself
    assign ready_go        = ~inst.res_from_div | (div_issued & div_complete);
    assign ex_allowin      = ~ex_valid | (ready_go & mem_allowin) | ex_flush;
    assign ex_to_mem_valid = ex_valid & ready_go & ~ex_flush;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (ex_allowin) begin
            ex_valid <= id_to_ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst  <= id_to_ex_data;
            excep <= id_to_ex_excep;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_issued <= 1'b0;
        end else if (accept) begin
            div_issued <= 1'b0;
        end else if (div_start) begin
            div_issued <= 1'b1;
        end
    end

    assign div_start  = ex_valid & inst.res_from_div & ~div_issued & ~ex_flush;
    assign div_signed = inst.div_signed;
    assign alu_op     = inst.alu_op;
    assign alu_src1   = inst.src1;
    assign alu_src2   = inst.src2;
    assign mul_signed = inst.mul_signed;

    // stable counter for rdcntvl / rdcntvh
    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer <= 64'd0;
        end else begin
            timer <= timer + 64'd1;
        end
    end

    assign result = inst.res_from_div ? (inst.div_r ? div_r : div_s) :
                    inst.rdcntvh      ? timer[63:32] :
                    inst.rdcntvl      ? timer[31:0]  :
                    alu_result;

    assign is_load  = inst.ld_b | inst.ld_bu | inst.ld_h | inst.ld_hu | inst.ld_w;
    assign addr_lo  = alu_result[1:0];
    assign st_lanes = ({4{inst.st_b}} & (4'b0001 << addr_lo))
                    | ({4{inst.st_h}} & (addr_lo[1] ? 4'b1100 : 4'b0011))
                    | {4{inst.st_w}};
    assign misalign = ((inst.ld_h | inst.ld_hu | inst.st_h) & addr_lo[0])
                    | ((inst.ld_w | inst.st_w) & (|addr_lo));
    assign ale      = ex_valid & misalign;

    assign data_sram_en    = ex_valid & (is_load | (|st_lanes)) & ~misalign
                           & ~ex_flush & ~mem_to_ex_excep;
    assign data_sram_we    = st_lanes & {4{ex_valid & ~misalign}};
    assign data_sram_addr  = {alu_result[31:2], 2'b00};
    assign data_sram_wdata = inst.st_b ? {4{inst.rkd_value[7:0]}}  :
                             inst.st_h ? {2{inst.rkd_value[15:0]}} :
                             inst.rkd_value;

    always_comb begin
        ex_to_mem_data.rf_we        = inst.rf_we;
        ex_to_mem_data.rf_waddr     = inst.rf_waddr;
        ex_to_mem_data.pc           = inst.pc;
        ex_to_mem_data.result       = result;
        ex_to_mem_data.ld_b         = inst.ld_b;
        ex_to_mem_data.ld_bu        = inst.ld_bu;
        ex_to_mem_data.ld_h         = inst.ld_h;
        ex_to_mem_data.ld_hu        = inst.ld_hu;
        ex_to_mem_data.ld_w         = inst.ld_w;
        ex_to_mem_data.res_from_mul = inst.res_from_mul;
        ex_to_mem_data.mul_h        = inst.mul_h;
        ex_to_mem_data.res_from_div = inst.res_from_div;
    end

    // decode leaves ale clear and it is filled in here
    always_comb begin
        ex_to_mem_excep     = excep;
        ex_to_mem_excep.ale = ale;
    end

    always_comb begin
        ex_fwd.res_from_csr = excep.res_from_csr;
        ex_fwd.blocking     = ex_valid & (is_load | inst.res_from_mul);
        ex_fwd.we           = ex_valid & inst.rf_we;
        ex_fwd.waddr        = inst.rf_waddr;
        ex_fwd.result       = result;
    end

    // the divider answers 33 cycles after its start unless a flush cuts it short
    div_latency_fixed: assert property (
        @(posedge clk) disable iff (!resetn || ex_flush)
        div_start |-> ##32 !div_complete ##1 div_complete);

    // back-pressure holds the memory request steady
    stall_holds_request: assert property (
        @(posedge clk) disable iff (!resetn)
        ex_valid && !ex_allowin |=> $stable(data_sram_we) && $stable(data_sram_addr)
                                    && $stable(data_sram_wdata));

endmodule

// ==== verilog/exe_unit.sv ====
module exe_unit (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 id_to_ex_valid,
    input  ex_pkg::id_to_ex_t    id_to_ex_data,
    input  ex_pkg::excep_t       id_to_ex_excep,
    output logic                 ex_allowin,
    input  logic                 mem_allowin,
    output logic                 ex_to_mem_valid,
    output ex_pkg::ex_to_mem_t   ex_to_mem_data,
    output ex_pkg::excep_t       ex_to_mem_excep,
    output ex_pkg::ex_fwd_t      ex_fwd,
    output logic [63:0]          mul_result,
    output logic                 data_sram_en,
    output logic [3:0]           data_sram_we,
    output logic [31:0]          data_sram_addr,
    output logic [31:0]          data_sram_wdata,
    input  logic                 ex_flush,
    input  logic                 mem_to_ex_excep
);
    logic [11:0] alu_op;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    logic [31:0] alu_result;
    logic        mul_signed;
    logic        div_start;
    logic        div_signed;
    logic [31:0] div_s;
    logic [31:0] div_r;
    logic        div_complete;
    logic        div_resetn;

    // a flush abandons any divide still in flight
    assign div_resetn = resetn & ~ex_flush;

    ex_stage ex_stage_i (
        .clk             (clk),
        .resetn          (resetn),
        .id_to_ex_valid  (id_to_ex_valid),
        .id_to_ex_data   (id_to_ex_data),
        .id_to_ex_excep  (id_to_ex_excep),
        .ex_allowin      (ex_allowin),
        .mem_allowin     (mem_allowin),
        .ex_to_mem_valid (ex_to_mem_valid),
        .ex_to_mem_data  (ex_to_mem_data),
        .ex_to_mem_excep (ex_to_mem_excep),
        .ex_fwd          (ex_fwd),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .ex_flush        (ex_flush),
        .mem_to_ex_excep (mem_to_ex_excep),
        .alu_op          (alu_op),
        .alu_src1        (alu_src1),
        .alu_src2        (alu_src2),
        .alu_result      (alu_result),
        .mul_signed      (mul_signed),
        .div_start       (div_start),
        .div_signed      (div_signed),
        .div_s           (div_s),
        .div_r           (div_r),
        .div_complete    (div_complete)
    );

    alu alu_i (
        .alu_op     (alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    mul mul_i (
        .clk        (clk),
        .resetn     (resetn),
        .mul_signed (mul_signed),
        .x          (alu_src1),
        .y          (alu_src2),
        .result     (mul_result)
    );

    div div_i (
        .clk        (clk),
        .resetn     (div_resetn),
        .start      (div_start),
        .div_signed (div_signed),
        .x          (alu_src1),
        .y          (alu_src2),
        .s          (div_s),
        .r          (div_r),
        .complete   (div_complete)
    );

endmodule

// ==== sim/tb_exe_unit.sv ====
module tb_exe_unit;
    timeunit 1ns;
    timeprecision 100ps;
    import ex_pkg::*;

    localparam int n_alu   = 200;
    localparam int n_mem   = 120;
    localparam int n_div   = 40;
    localparam int n_mul   = 60;
    localparam int n_timer = 20;
    // divides counted at 40 cycles and everything else at 4
    localparam int test_cycles = (n_alu + n_mem + 2 * n_mul + n_timer + 14) * 4
                               + (n_div + 2) * 40;
    localparam int watchdog_cycles = test_cycles * 2 + 1000;
    // start in the first cycle, complete 33 cycles later
    localparam int div_latency = 34;

    logic        clk = 1'b0;
    logic        resetn;
    logic        id_to_ex_valid;
    id_to_ex_t   id_to_ex_data;
    excep_t      id_to_ex_excep;
    logic        ex_allowin;
    logic        mem_allowin;
    logic        ex_to_mem_valid;
    ex_to_mem_t  ex_to_mem_data;
    excep_t      ex_to_mem_excep;
    ex_fwd_t     ex_fwd;
    logic [63:0] mul_result;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic        ex_flush;
    logic        mem_to_ex_excep;

    logic [31:0] lfsr = 32'h3e06_a0da;
    logic [63:0] cycle_cnt;
    int          checks = 0;
    int          errors = 0;
    int          tests_run = 0;

    exe_unit dut_i (.*);

    always #4 clk = ~clk;

    // reference cycle counter that stays zero until reset ends
    always @(posedge clk) begin
        if (!resetn) begin
            cycle_cnt <= 64'd0;
        end else begin
            cycle_cnt <= cycle_cnt + 64'd1;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = 32'd0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] v;
        v = rand_bits(1);
        return v[0];
    endfunction

    function automatic excep_t rand_excep();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        excep_t      e;
        a = rand_bits(32);
        b = rand_bits(32);
        c = rand_bits(23);
        e = {a, b, c[22:0]};
        e.ale = 1'b0;
        return e;
    endfunction

    function automatic id_to_ex_t base_inst();
        id_to_ex_t d;
        d = '0;
        d.src1      = rand_bits(32);
        d.src2      = rand_bits(32);
        d.rf_we     = rand_bit();
        d.rf_waddr  = 5'(rand_bits(5));
        d.pc        = rand_bits(30) << 2;
        d.rkd_value = rand_bits(32);
        return d;
    endfunction

    function automatic logic [31:0] alu_model(input logic [11:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] res;
        logic [31:0] sra_v;
        sra_v = $signed(a) >>> b[4:0];
        res = 32'd0;
        if (op[alu_add])  res = res | (a + b);
        if (op[alu_sub])  res = res | (a - b);
        if (op[alu_slt])  res = res | {31'd0, $signed(a) < $signed(b)};
        if (op[alu_sltu]) res = res | {31'd0, a < b};
        if (op[alu_and])  res = res | (a & b);
        if (op[alu_nor])  res = res | ~(a | b);
        if (op[alu_or])   res = res | (a | b);
        if (op[alu_xor])  res = res | (a ^ b);
        if (op[alu_sll])  res = res | (a << b[4:0]);
        if (op[alu_srl])  res = res | (a >> b[4:0]);
        if (op[alu_sra])  res = res | sra_v;
        if (op[alu_lui])  res = res | b;
        return res;
    endfunction

    function automatic logic [31:0] div_model(input logic sgn, input logic want_r,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] ua;
        logic [31:0] ub;
        logic [31:0] q;
        logic [31:0] r;
        logic        neg_a;
        logic        neg_b;
        neg_a = sgn & a[31];
        neg_b = sgn & b[31];
        if (b == 32'd0) begin
            q = 32'hffff_ffff;
            r = a;
        end else begin
            ua = neg_a ? -a : a;
            ub = neg_b ? -b : b;
            q = ua / ub;
            r = ua % ub;
            if (neg_a ^ neg_b) q = -q;
            if (neg_a) r = -r;
        end
        return want_r ? r : q;
    endfunction

    function automatic logic [63:0] mul_model(input logic sgn, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [63:0] ea;
        logic [63:0] eb;
        ea = {{32{sgn & a[31]}}, a};
        eb = {{32{sgn & b[31]}}, b};
        return ea * eb;
    endfunction

    task automatic model(input id_to_ex_t d, input excep_t e, input logic mem_x,
                         input logic [63:0] cnt, output ex_to_mem_t md, output excep_t mx,
                         output logic en, output logic [3:0] we, output logic [31:0] addr,
                         output logic [31:0] wdata);
        logic [31:0] alu_v;
        logic        bad;
        alu_v = alu_model(d.alu_op, d.src1, d.src2);
        md = '0;
        if (d.res_from_div) begin
            md.result = div_model(d.div_signed, d.div_r, d.src1, d.src2);
        end else if (d.rdcntvh) begin
            md.result = cnt[63:32];
        end else if (d.rdcntvl) begin
            md.result = cnt[31:0];
        end else begin
            md.result = alu_v;
        end
        bad = ((d.ld_h | d.ld_hu | d.st_h) & alu_v[0])
            | ((d.ld_w | d.st_w) & (alu_v[1:0] != 2'b00));
        en = (d.ld_b | d.ld_bu | d.ld_h | d.ld_hu | d.ld_w | d.st_b | d.st_h | d.st_w)
           & ~bad & ~mem_x;
        we = 4'd0;
        if (!bad && d.st_b) we = 4'b0001 << alu_v[1:0];
        if (!bad && d.st_h) we = alu_v[1] ? 4'b1100 : 4'b0011;
        if (!bad && d.st_w) we = 4'b1111;
        addr  = {alu_v[31:2], 2'b00};
        wdata = d.st_b ? {4{d.rkd_value[7:0]}} : d.st_h ? {2{d.rkd_value[15:0]}} : d.rkd_value;
        md.rf_we        = d.rf_we;
        md.rf_waddr     = d.rf_waddr;
        md.pc           = d.pc;
        md.ld_b         = d.ld_b;
        md.ld_bu        = d.ld_bu;
        md.ld_h         = d.ld_h;
        md.ld_hu        = d.ld_hu;
        md.ld_w         = d.ld_w;
        md.res_from_mul = d.res_from_mul;
        md.mul_h        = d.mul_h;
        md.res_from_div = d.res_from_div;
        mx = e;
        mx.ale = bad;
    endtask

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("** Error %s expected %0h got %0h", name, exp, got);
        end
    endtask

    task automatic issue(input id_to_ex_t d, input excep_t e);
        id_to_ex_valid = 1'b1;
        id_to_ex_data  = d;
        id_to_ex_excep = e;
        @(negedge clk);
        check("ex_allowin", 128'(1), 128'(ex_allowin));
        @(posedge clk);
        #1;
        id_to_ex_valid = 1'b0;
    endtask

    // waits for the transfer to mem with optional stalls and mem exceptions
    task automatic retire(input id_to_ex_t d, input excep_t e, input logic stall,
                          input logic mx_rand);
        ex_to_mem_t  md;
        excep_t      mx;
        logic        en;
        logic [3:0]  we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        mem_op;
        logic        done;
        logic        exp_valid;
        int          waited;
        mem_op = d.ld_b | d.ld_bu | d.ld_h | d.ld_hu | d.ld_w | d.st_b | d.st_h | d.st_w;
        done = 1'b0;
        waited = 0;
        while (!done) begin
            waited++;
            mem_allowin     = stall ? (rand_bits(2) != 32'd0) : 1'b1;
            mem_to_ex_excep = mx_rand ? (rand_bits(2) == 32'd0) : 1'b0;
            exp_valid = !d.res_from_div || waited >= div_latency;
            @(negedge clk);
            check("ex_to_mem_valid", 128'(exp_valid), 128'(ex_to_mem_valid));
            check("ex_allowin", 128'(exp_valid & mem_allowin), 128'(ex_allowin));
            if (exp_valid && mem_allowin) begin
                model(d, e, mem_to_ex_excep, cycle_cnt, md, mx, en, we, addr, wdata);
                check("ex_to_mem_data.result", 128'(md.result), 128'(ex_to_mem_data.result));
                check("ex_to_mem_data", 128'(md), 128'(ex_to_mem_data));
                check("ex_to_mem_excep", 128'(mx), 128'(ex_to_mem_excep));
                check("ex_fwd.res_from_csr", 128'(e.res_from_csr), 128'(ex_fwd.res_from_csr));
                check("ex_fwd.blocking", 128'(d.ld_b | d.ld_bu | d.ld_h | d.ld_hu | d.ld_w
                      | d.res_from_mul), 128'(ex_fwd.blocking));
                check("ex_fwd.we", 128'(d.rf_we), 128'(ex_fwd.we));
                check("ex_fwd.waddr", 128'(d.rf_waddr), 128'(ex_fwd.waddr));
                check("ex_fwd.result", 128'(md.result), 128'(ex_fwd.result));
                check("data_sram_en", 128'(en), 128'(data_sram_en));
                check("data_sram_we", 128'(we), 128'(data_sram_we));
                if (mem_op) begin
                    check("data_sram_addr", 128'(addr), 128'(data_sram_addr));
                    check("data_sram_wdata", 128'(wdata), 128'(data_sram_wdata));
                end
                done = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        mem_allowin     = 1'b1;
        mem_to_ex_excep = 1'b0;
    endtask

    task automatic report(input string name, input int count, input int err_before);
        tests_run++;
        $display("%s: %0d instructions, %0d errors", name, count, errors - err_before);
    endtask

    task automatic test_reset();
        int start_err;
        start_err = errors;
        @(negedge clk);
        check("ex_to_mem_valid", 128'(0), 128'(ex_to_mem_valid));
        check("data_sram_en", 128'(0), 128'(data_sram_en));
        check("ex_fwd.blocking", 128'(0), 128'(ex_fwd.blocking));
        check("ex_fwd.we", 128'(0), 128'(ex_fwd.we));
        check("ex_allowin", 128'(1), 128'(ex_allowin));
        @(posedge clk);
        #1;
        report("reset", 0, start_err);
    endtask

    task automatic test_alu();
        id_to_ex_t d;
        excep_t    e;
        int        idx;
        int        i;
        int        start_err;
        start_err = errors;
        for (i = 0; i < n_alu; i++) begin
            d = base_inst();
            idx = int'(rand_bits(4) % 12);
            d.alu_op = 12'd1 << idx;
            e = rand_excep();
            issue(d, e);
            retire(d, e, 1'b1, 1'b0);
        end
        report("alu ops", n_alu, start_err);
    endtask

    task automatic test_mem();
        id_to_ex_t   d;
        excep_t      e;
        logic [31:0] kind;
        int          i;
        int          start_err;
        start_err = errors;
        for (i = 0; i < n_mem; i++) begin
            d = base_inst();
            d.alu_op = 12'd1 << alu_add;
            d.src2 = rand_bits(4);
            kind = rand_bits(3);
            case (kind[2:0])
                3'd0: d.ld_b = 1'b1;
                3'd1: d.ld_bu = 1'b1;
                3'd2: d.ld_h = 1'b1;
                3'd3: d.ld_hu = 1'b1;
                3'd4: d.ld_w = 1'b1;
                3'd5: d.st_b = 1'b1;
                3'd6: d.st_h = 1'b1;
                default: d.st_w = 1'b1;
            endcase
            e = rand_excep();
            issue(d, e);
            retire(d, e, 1'b1, 1'b1);
        end
        report("loads and stores", n_mem, start_err);
    endtask

    task automatic test_div();
        id_to_ex_t d;
        excep_t    e;
        int        i;
        int        start_err;
        start_err = errors;
        for (i = 0; i < n_div; i++) begin
            d = base_inst();
            d.res_from_div = 1'b1;
            d.div_signed = rand_bit();
            d.div_r = rand_bit();
            if (i % 8 == 0) begin
                d.src2 = 32'd0;
            end else if (i % 8 == 1) begin
                d.src1 = 32'h8000_0000;
                d.src2 = 32'hffff_ffff;
                d.div_signed = 1'b1;
            end else if (i % 8 == 2) begin
                d.src2 = rand_bits(8);
            end
            e = rand_excep();
            issue(d, e);
            retire(d, e, 1'b1, 1'b0);
        end
        report("divide", n_div, start_err);
    endtask

    task automatic test_mul();
        id_to_ex_t d;
        excep_t    e;
        int        i;
        int        start_err;
        start_err = errors;
        for (i = 0; i < n_mul; i++) begin
            d = base_inst();
            d.res_from_mul = 1'b1;
            d.mul_signed = rand_bit();
            d.mul_h = rand_bit();
            e = rand_excep();
            issue(d, e);
            retire(d, e, 1'b1, 1'b0);
            // product shows up one cycle after the transfer
            @(negedge clk);
            check("mul_result", 128'(mul_model(d.mul_signed, d.src1, d.src2)), 128'(mul_result));
            @(posedge clk);
            #1;
        end
        report("multiply", n_mul, start_err);
    endtask

    task automatic test_timer();
        id_to_ex_t d;
        excep_t    e;
        int        i;
        int        start_err;
        start_err = errors;
        for (i = 0; i < n_timer; i++) begin
            d = base_inst();
            if (rand_bit()) begin
                d.rdcntvh = 1'b1;
            end else begin
                d.rdcntvl = 1'b1;
            end
            e = rand_excep();
            issue(d, e);
            retire(d, e, 1'b1, 1'b0);
        end
        report("timer", n_timer, start_err);
    endtask

    task automatic test_flush();
        id_to_ex_t d;
        excep_t    e;
        int        i;
        int        start_err;
        start_err = errors;
        d = base_inst();
        d.res_from_div = 1'b1;
        e = rand_excep();
        issue(d, e);
        for (i = 0; i < 12; i++) begin
            @(negedge clk);
            check("ex_to_mem_valid", 128'(0), 128'(ex_to_mem_valid));
            @(posedge clk);
            #1;
        end
        ex_flush = 1'b1;
        @(negedge clk);
        check("ex_to_mem_valid", 128'(0), 128'(ex_to_mem_valid));
        check("ex_allowin", 128'(1), 128'(ex_allowin));
        @(posedge clk);
        #1;
        ex_flush = 1'b0;
        @(negedge clk);
        check("ex_to_mem_valid", 128'(0), 128'(ex_to_mem_valid));
        @(posedge clk);
        #1;
        d = base_inst();
        d.res_from_div = 1'b1;
        d.div_signed = rand_bit();
        d.div_r = rand_bit();
        e = rand_excep();
        issue(d, e);
        retire(d, e, 1'b0, 1'b0);
        report("flush", 2, start_err);
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        resetn          = 1'b0;
        id_to_ex_valid  = 1'b0;
        id_to_ex_data   = '0;
        id_to_ex_excep  = '0;
        mem_allowin     = 1'b1;
        ex_flush        = 1'b0;
        mem_to_ex_excep = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;
        test_reset();
        test_alu();
        test_mem();
        test_div();
        test_mul();
        test_timer();
        test_flush();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
common/ex_pkg.sv
verilog/alu.sv
verilog/mul.sv
verilog/div.sv
ex_stage/ex_stage.sv
verilog/exe_unit.sv
sim/tb_exe_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exe_unit
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/100ps

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
